/* src/misty1_pkg.sv */
// MISTY1 shared definitions
package misty1_pkg;

	localparam int key_w = 128;
	localparam int block_w = 64;
	localparam int half_w = 32;
	localparam int word_w = 16;
	localparam int ko_w = 64;
	localparam int ki_w = 48;

	localparam int num_rounds = 9; // 8 rounds plus output cycle
	localparam int sched_rounds = 8;

	typedef logic [num_rounds-1:0] round_t;

	typedef enum logic [1:0] {
		st_idle,
		st_key_sched,
		st_encrypt,
		st_decrypt
	} state_t;

	typedef enum logic {
		dir_encrypt = 1'b0,
		dir_decrypt = 1'b1
	} dir_t;

	// Round positions
	localparam round_t round_init = 9'b0_0000_0001;
	localparam round_t odd_mask = 9'b0_1010_1010;
	localparam round_t even_mask = 9'b0_0101_0101;
	localparam int out_pos = num_rounds - 1;
	localparam logic [2:0] sched_last = 3'(sched_rounds - 1);
	localparam logic [2:0] kl_last = 3'd4; // Last FL layer

	function automatic logic [half_w-1:0] fl(input logic [half_w-1:0] x,
			input logic [half_w-1:0] kl);
		logic [word_w-1:0] t_r;
		t_r = x[word_w-1:0] ^ (x[half_w-1:word_w] & kl[half_w-1:word_w]);
		return {x[half_w-1:word_w] ^ (t_r | kl[word_w-1:0]), t_r};
	endfunction

	function automatic logic [half_w-1:0] fl_inv(input logic [half_w-1:0] x,
			input logic [half_w-1:0] kl);
		logic [word_w-1:0] t_l;
		t_l = x[half_w-1:word_w] ^ (x[word_w-1:0] | kl[word_w-1:0]);
		return {t_l, x[word_w-1:0] ^ (t_l & kl[half_w-1:word_w])};
	endfunction

endpackage

/* src/round_key_if.sv */
// Round key bus
interface round_key_if;

	logic [misty1_pkg::ko_w-1:0] ko;
	logic [misty1_pkg::ki_w-1:0] ki;
	logic [misty1_pkg::half_w-1:0] kl1;
	logic [misty1_pkg::half_w-1:0] kl2;
	logic [misty1_pkg::half_w-1:0] sched_to_fi; // Word pair for middle FI
	logic [misty1_pkg::word_w-1:0] fi_to_sched; // Derived key word

	modport key_side (
		output ko,
		output ki,
		output kl1,
		output kl2,
		output sched_to_fi,
		input fi_to_sched
	);

	modport data_side (
		input ko,
		input ki,
		input kl1,
		input kl2,
		input sched_to_fi,
		output fi_to_sched
	);

endinterface

/* src/misty1_fi.sv */
// MISTY1 FI function
module misty1_fi (
	input logic [misty1_pkg::word_w-1:0] fi_in,
	input logic [misty1_pkg::word_w-1:0] fi_key,
	output logic [misty1_pkg::word_w-1:0] fi_out
);

	localparam logic [6:0] s7_tab [0:127] = '{
		7'h1b, 7'h32, 7'h33, 7'h5a, 7'h3b, 7'h10, 7'h17, 7'h54,
		7'h5b, 7'h1a, 7'h72, 7'h73, 7'h6b, 7'h2c, 7'h66, 7'h49,
		7'h1f, 7'h24, 7'h13, 7'h6c, 7'h37, 7'h2e, 7'h3f, 7'h4a,
		7'h5d, 7'h0f, 7'h40, 7'h56, 7'h25, 7'h51, 7'h1c, 7'h04,
		7'h0b, 7'h46, 7'h20, 7'h0d, 7'h7b, 7'h35, 7'h44, 7'h42,
		7'h2b, 7'h1e, 7'h41, 7'h14, 7'h4b, 7'h79, 7'h15, 7'h6f,
		7'h0e, 7'h55, 7'h09, 7'h36, 7'h74, 7'h0c, 7'h67, 7'h53,
		7'h28, 7'h0a, 7'h7e, 7'h38, 7'h02, 7'h07, 7'h60, 7'h29,
		7'h19, 7'h12, 7'h65, 7'h2f, 7'h30, 7'h39, 7'h08, 7'h68,
		7'h5f, 7'h78, 7'h2a, 7'h4c, 7'h64, 7'h45, 7'h75, 7'h3d,
		7'h59, 7'h48, 7'h03, 7'h57, 7'h7c, 7'h4f, 7'h62, 7'h3c,
		7'h1d, 7'h21, 7'h5e, 7'h27, 7'h6a, 7'h70, 7'h4d, 7'h3a,
		7'h01, 7'h6d, 7'h6e, 7'h63, 7'h18, 7'h77, 7'h23, 7'h05,
		7'h26, 7'h76, 7'h00, 7'h31, 7'h2d, 7'h7a, 7'h7f, 7'h61,
		7'h50, 7'h22, 7'h11, 7'h06, 7'h47, 7'h16, 7'h52, 7'h4e,
		7'h71, 7'h3e, 7'h69, 7'h43, 7'h34, 7'h5c, 7'h58, 7'h7d
	};

	localparam logic [8:0] s9_tab [0:511] = '{
		9'h1c3, 9'h0cb, 9'h153, 9'h19f, 9'h1e3, 9'h0e9, 9'h0fb, 9'h035,
		9'h181, 9'h0b9, 9'h117, 9'h1eb, 9'h133, 9'h009, 9'h02d, 9'h0d3,
		9'h0c7, 9'h14a, 9'h037, 9'h07e, 9'h0eb, 9'h164, 9'h193, 9'h1d8,
		9'h0a3, 9'h11e, 9'h055, 9'h02c, 9'h01d, 9'h1a2, 9'h163, 9'h118,
		9'h14b, 9'h152, 9'h1d2, 9'h00f, 9'h02b, 9'h030, 9'h13a, 9'h0e5,
		9'h111, 9'h138, 9'h18e, 9'h063, 9'h0e3, 9'h0c8, 9'h1f4, 9'h01b,
		9'h001, 9'h09d, 9'h0f8, 9'h1a0, 9'h16d, 9'h1f3, 9'h01c, 9'h146,
		9'h07d, 9'h0d1, 9'h082, 9'h1ea, 9'h183, 9'h12d, 9'h0f4, 9'h19e,
		9'h1d3, 9'h0dd, 9'h1e2, 9'h128, 9'h1e0, 9'h0ec, 9'h059, 9'h091,
		9'h011, 9'h12f, 9'h026, 9'h0dc, 9'h0b0, 9'h18c, 9'h10f, 9'h1f7,
		9'h0e7, 9'h16c, 9'h0b6, 9'h0f9, 9'h0d8, 9'h151, 9'h101, 9'h14c,
		9'h103, 9'h0b8, 9'h154, 9'h12b, 9'h1ae, 9'h017, 9'h071, 9'h00c,
		9'h047, 9'h058, 9'h07f, 9'h1a4, 9'h134, 9'h129, 9'h084, 9'h15d,
		9'h19d, 9'h1b2, 9'h1a3, 9'h048, 9'h07c, 9'h051, 9'h1ca, 9'h023,
		9'h13d, 9'h1a7, 9'h165, 9'h03b, 9'h042, 9'h0da, 9'h192, 9'h0ce,
		9'h0c1, 9'h06b, 9'h09f, 9'h1f1, 9'h12c, 9'h184, 9'h0fa, 9'h196,
		9'h1e1, 9'h169, 9'h17d, 9'h031, 9'h180, 9'h10a, 9'h094, 9'h1da,
		9'h186, 9'h13e, 9'h11c, 9'h060, 9'h175, 9'h1cf, 9'h067, 9'h119,
		9'h065, 9'h068, 9'h099, 9'h150, 9'h008, 9'h007, 9'h17c, 9'h0b7,
		9'h024, 9'h019, 9'h0de, 9'h127, 9'h0db, 9'h0e4, 9'h1a9, 9'h052,
		9'h109, 9'h090, 9'h19c, 9'h1c1, 9'h028, 9'h1b3, 9'h135, 9'h16a,
		9'h176, 9'h0df, 9'h1e5, 9'h188, 9'h0c5, 9'h16e, 9'h1de, 9'h1b1,
		9'h0c3, 9'h1df, 9'h036, 9'h0ee, 9'h1ee, 9'h0f0, 9'h093, 9'h049,
		9'h09a, 9'h1b6, 9'h069, 9'h081, 9'h125, 9'h00b, 9'h05e, 9'h0b4,
		9'h149, 9'h1c7, 9'h174, 9'h03e, 9'h13b, 9'h1b7, 9'h08e, 9'h1c6,
		9'h0ae, 9'h010, 9'h095, 9'h1ef, 9'h04e, 9'h0f2, 9'h1fd, 9'h085,
		9'h0fd, 9'h0f6, 9'h0a0, 9'h16f, 9'h083, 9'h08a, 9'h156, 9'h09b,
		9'h13c, 9'h107, 9'h167, 9'h098, 9'h1d0, 9'h1e9, 9'h003, 9'h1fe,
		9'h0bd, 9'h122, 9'h089, 9'h0d2, 9'h18f, 9'h012, 9'h033, 9'h06a,
		9'h142, 9'h0ed, 9'h170, 9'h11b, 9'h0e2, 9'h14f, 9'h158, 9'h131,
		9'h147, 9'h05d, 9'h113, 9'h1cd, 9'h079, 9'h161, 9'h1a5, 9'h179,
		9'h09e, 9'h1b4, 9'h0cc, 9'h022, 9'h132, 9'h01a, 9'h0e8, 9'h004,
		9'h187, 9'h1ed, 9'h197, 9'h039, 9'h1bf, 9'h1d7, 9'h027, 9'h18b,
		9'h0c6, 9'h09c, 9'h0d0, 9'h14e, 9'h06c, 9'h034, 9'h1f2, 9'h06e,
		9'h0ca, 9'h025, 9'h0ba, 9'h191, 9'h0fe, 9'h013, 9'h106, 9'h02f,
		9'h1ad, 9'h172, 9'h1db, 9'h0c0, 9'h10b, 9'h1d6, 9'h0f5, 9'h1ec,
		9'h10d, 9'h076, 9'h114, 9'h1ab, 9'h075, 9'h10c, 9'h1e4, 9'h159,
		9'h054, 9'h11f, 9'h04b, 9'h0c4, 9'h1be, 9'h0f7, 9'h029, 9'h0a4,
		9'h00e, 9'h1f0, 9'h077, 9'h04d, 9'h17a, 9'h086, 9'h08b, 9'h0b3,
		9'h171, 9'h0bf, 9'h10e, 9'h104, 9'h097, 9'h15b, 9'h160, 9'h168,
		9'h0d7, 9'h0bb, 9'h066, 9'h1ce, 9'h0fc, 9'h092, 9'h1c5, 9'h06f,
		9'h016, 9'h04a, 9'h0a1, 9'h139, 9'h0af, 9'h0f1, 9'h190, 9'h00a,
		9'h1aa, 9'h143, 9'h17b, 9'h056, 9'h18d, 9'h166, 9'h0d4, 9'h1fb,
		9'h14d, 9'h194, 9'h19a, 9'h087, 9'h1f8, 9'h123, 9'h0a7, 9'h1b8,
		9'h141, 9'h03c, 9'h1f9, 9'h140, 9'h02a, 9'h155, 9'h11a, 9'h1a1,
		9'h198, 9'h0d5, 9'h126, 9'h1af, 9'h061, 9'h12e, 9'h157, 9'h1dc,
		9'h072, 9'h18a, 9'h0aa, 9'h096, 9'h115, 9'h0ef, 9'h045, 9'h07b,
		9'h08d, 9'h145, 9'h053, 9'h05f, 9'h178, 9'h0b2, 9'h02e, 9'h020,
		9'h1d5, 9'h03f, 9'h1c9, 9'h1e7, 9'h1ac, 9'h044, 9'h038, 9'h014,
		9'h0b1, 9'h16b, 9'h0ab, 9'h0b5, 9'h05a, 9'h182, 9'h1c8, 9'h1d4,
		9'h018, 9'h177, 9'h064, 9'h0cf, 9'h06d, 9'h100, 9'h199, 9'h130,
		9'h15a, 9'h005, 9'h120, 9'h1bb, 9'h1bd, 9'h0e0, 9'h04f, 9'h0d6,
		9'h13f, 9'h1c4, 9'h12a, 9'h015, 9'h006, 9'h0ff, 9'h19b, 9'h0a6,
		9'h043, 9'h088, 9'h050, 9'h15f, 9'h1e8, 9'h121, 9'h073, 9'h17e,
		9'h0bc, 9'h0c2, 9'h0c9, 9'h173, 9'h189, 9'h1f5, 9'h074, 9'h1cc,
		9'h1e6, 9'h1a8, 9'h195, 9'h01f, 9'h041, 9'h00d, 9'h1ba, 9'h032,
		9'h03d, 9'h1d1, 9'h080, 9'h0a8, 9'h057, 9'h1b9, 9'h162, 9'h148,
		9'h0d9, 9'h105, 9'h062, 9'h07a, 9'h021, 9'h1ff, 9'h112, 9'h108,
		9'h1c0, 9'h0a9, 9'h11d, 9'h1b0, 9'h1a6, 9'h0cd, 9'h0f3, 9'h05c,
		9'h102, 9'h05b, 9'h1d9, 9'h144, 9'h1f6, 9'h0ad, 9'h0a5, 9'h03a,
		9'h1cb, 9'h136, 9'h17f, 9'h046, 9'h0e1, 9'h01e, 9'h1dd, 9'h0e6,
		9'h137, 9'h1fa, 9'h185, 9'h08c, 9'h08f, 9'h040, 9'h1b5, 9'h0be,
		9'h078, 9'h000, 9'h0ac, 9'h110, 9'h15e, 9'h124, 9'h002, 9'h1bc,
		9'h0a2, 9'h0ea, 9'h070, 9'h1fc, 9'h116, 9'h15c, 9'h04c, 9'h1c2
	};

	logic [8:0] in9, key9, r1_9, r2_9, r3_9;
	logic [6:0] in7, key7, r2_7;

	assign {in9, in7} = fi_in; // Data splits 9/7
	assign {key7, key9} = fi_key; // Key splits 7/9

	assign r1_9 = s9_tab[in9] ^ {2'b00, in7};
	assign r2_9 = r1_9 ^ key9;
	assign r2_7 = s7_tab[in7] ^ r1_9[6:0] ^ key7;
	assign r3_9 = s9_tab[r2_9] ^ {2'b00, r2_7};

	assign fi_out = {r2_7, r3_9};

endmodule

/* src/misty1_fo.sv */
// MISTY1 FO function
module misty1_fo (
	input logic [misty1_pkg::half_w-1:0] fo_in,
	input logic [misty1_pkg::ko_w-1:0] ko,
	input logic [misty1_pkg::ki_w-1:0] ki,
	input misty1_pkg::state_t state,
	input logic [misty1_pkg::half_w-1:0] sched_to_fi,
	output logic [misty1_pkg::half_w-1:0] fo_out,
	output logic [misty1_pkg::word_w-1:0] fi_to_sched
);

	localparam int ww = misty1_pkg::word_w;

	logic [ww-1:0] ko1, ko2, ko3, ko4;
	logic [ww-1:0] ki1, ki2, ki3;
	logic [ww-1:0] fi1_in, fi1_out;
	logic [ww-1:0] fi2_in, fi2_key, fi2_out;
	logic [ww-1:0] fi3_in, fi3_out;
	logic [2*ww-1:0] r1, r2, r3;
	logic in_sched;

	assign {ko1, ko2, ko3, ko4} = ko;
	assign {ki1, ki2, ki3} = ki;
	assign in_sched = state == misty1_pkg::st_key_sched;

	misty1_fi u_fi1 (.fi_in(fi1_in), .fi_key(ki1), .fi_out(fi1_out));
	misty1_fi u_fi2 (.fi_in(fi2_in), .fi_key(fi2_key), .fi_out(fi2_out));
	misty1_fi u_fi3 (.fi_in(fi3_in), .fi_key(ki3), .fi_out(fi3_out));

	assign fi1_in = fo_in[2*ww-1:ww] ^ ko1;
	assign r1 = {fo_in[ww-1:0], fi1_out ^ fo_in[ww-1:0]};

	// Middle stage is borrowed by the key schedule
	assign fi2_in = in_sched ? sched_to_fi[2*ww-1:ww] : r1[2*ww-1:ww] ^ ko2;
	assign fi2_key = in_sched ? sched_to_fi[ww-1:0] : ki2;
	assign r2 = {r1[ww-1:0], fi2_out ^ r1[ww-1:0]};
	assign fi_to_sched = fi2_out;

	assign fi3_in = r2[2*ww-1:ww] ^ ko3;
	assign r3 = {r2[ww-1:0], fi3_out ^ r2[ww-1:0]};

	assign fo_out = {r3[2*ww-1:ww] ^ ko4, r3[ww-1:0]};

endmodule

/* src/misty1_control.sv */
// MISTY1 sequencer
module misty1_control (
	input logic clk,
	input logic nreset,
	input logic key_rdy,
	input logic data_rdy,
	input logic enc_dec,
	output misty1_pkg::state_t state,
	output misty1_pkg::round_t round,
	output logic busy,
	output logic key_valid,
	output logic data_valid
);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= misty1_pkg::st_idle;
			round <= misty1_pkg::round_init;
		end else begin
			case (state)
			misty1_pkg::st_idle: begin
				if (key_rdy) begin // Key load wins
					state <= misty1_pkg::st_key_sched;
				end else if (data_rdy) begin
					if (misty1_pkg::dir_t'(enc_dec) == misty1_pkg::dir_encrypt)
						state <= misty1_pkg::st_encrypt;
					else
						state <= misty1_pkg::st_decrypt;
				end
			end
			misty1_pkg::st_key_sched: begin
				if (round[misty1_pkg::sched_last]) begin
					state <= misty1_pkg::st_idle;
					round <= misty1_pkg::round_init;
				end else begin
					round <= {round[misty1_pkg::num_rounds-2:0],
						round[misty1_pkg::num_rounds-1]};
				end
			end
			default: begin
				// Rotation wraps back to position 0 after the output cycle
				if (round[misty1_pkg::out_pos])
					state <= misty1_pkg::st_idle;
				round <= {round[misty1_pkg::num_rounds-2:0],
					round[misty1_pkg::num_rounds-1]};
			end
			endcase
		end
	end

	assign busy = state != misty1_pkg::st_idle;
	assign key_valid = state != misty1_pkg::st_key_sched;
	assign data_valid = round[misty1_pkg::out_pos] &&
		(state == misty1_pkg::st_encrypt || state == misty1_pkg::st_decrypt);

endmodule

/* src/misty1_key_sched.sv */
// MISTY1 key registers and subkey select
module misty1_key_sched (
	input logic clk,
	input logic nreset,
	input logic key_rdy,
	input logic [misty1_pkg::key_w-1:0] data_in,
	input logic enc_dec,
	input misty1_pkg::state_t state,
	input misty1_pkg::round_t round,
	round_key_if.key_side rk
);

	logic [misty1_pkg::word_w-1:0] k_w [misty1_pkg::sched_rounds]; // K1..K8
	logic [misty1_pkg::word_w-1:0] kp_w [misty1_pkg::sched_rounds]; // K'1..K'8
	logic [3:0] pos;
	logic [2:0] ko_idx;
	logic [2:0] kl_idx;
	logic is_enc;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < misty1_pkg::sched_rounds; i++) begin
				k_w[i] <= '0;
				kp_w[i] <= '0;
			end
		end else begin
			case (state)
			misty1_pkg::st_idle: begin
				if (key_rdy) begin
					for (int i = 0; i < misty1_pkg::sched_rounds; i++)
						k_w[i] <= data_in[misty1_pkg::key_w - 1 - i * misty1_pkg::word_w
							-: misty1_pkg::word_w];
				end
			end
			misty1_pkg::st_key_sched: begin
				for (int i = 0; i < misty1_pkg::sched_rounds; i++)
					if (round[i])
						kp_w[i] <= rk.fi_to_sched; // K'i = FI(Ki, Ki+1)
			end
			default: ;
			endcase
		end
	end

	// One-hot to binary position
	always_comb begin
		pos = '0;
		for (int i = 0; i < misty1_pkg::num_rounds; i++)
			if (round[i])
				pos = 4'(i);
	end

	assign is_enc = misty1_pkg::dir_t'(enc_dec) == misty1_pkg::dir_encrypt;

	// Decryption walks the schedule backwards
	assign ko_idx = is_enc ? pos[2:0] : misty1_pkg::sched_last - pos[2:0];
	assign kl_idx = is_enc ? pos[3:1] : misty1_pkg::kl_last - pos[3:1];

	assign rk.sched_to_fi = {k_w[pos[2:0]], k_w[pos[2:0] + 3'd1]};

	// Word indices wrap mod 8
	assign rk.ko = {k_w[ko_idx], k_w[ko_idx + 3'd2], k_w[ko_idx + 3'd7], k_w[ko_idx + 3'd4]};
	assign rk.ki = {kp_w[ko_idx + 3'd5], kp_w[ko_idx + 3'd1], kp_w[ko_idx + 3'd3]};
	assign rk.kl1 = {k_w[kl_idx], kp_w[kl_idx + 3'd6]};
	assign rk.kl2 = {kp_w[kl_idx + 3'd2], k_w[kl_idx + 3'd4]};

endmodule

/* src/misty1_datapath.sv */
// MISTY1 block datapath
module misty1_datapath (
	input logic clk,
	input logic nreset,
	input logic data_rdy,
	input logic key_rdy,
	input logic enc_dec,
	input logic [misty1_pkg::key_w-1:0] data_in,
	input misty1_pkg::state_t state,
	input misty1_pkg::round_t round,
	output logic [misty1_pkg::block_w-1:0] data_out,
	round_key_if.data_side rk
);

	localparam int hw = misty1_pkg::half_w;

	logic [misty1_pkg::block_w-1:0] data_reg;
	logic [misty1_pkg::block_w-1:0] fl_out, fl_inv_out;
	logic [misty1_pkg::block_w-1:0] fe_in, fe_out, fe_sel, data_next;
	logic [hw-1:0] fo_out;
	logic is_enc, odd_pos, even_pos, last_pos;

	assign is_enc = misty1_pkg::dir_t'(enc_dec) == misty1_pkg::dir_encrypt;
	assign odd_pos = |(round & misty1_pkg::odd_mask);
	assign even_pos = |(round & misty1_pkg::even_mask);
	assign last_pos = round[misty1_pkg::out_pos];

	assign fl_out = {misty1_pkg::fl(data_reg[2*hw-1:hw], rk.kl1),
		misty1_pkg::fl(data_reg[hw-1:0], rk.kl2)};
	assign fl_inv_out = {misty1_pkg::fl_inv(data_reg[2*hw-1:hw], rk.kl1),
		misty1_pkg::fl_inv(data_reg[hw-1:0], rk.kl2)};

	always_comb begin
		if (is_enc)
			fe_in = odd_pos ? data_reg : fl_out;
		else if (even_pos)
			fe_in = {fl_inv_out[hw-1:0], fl_inv_out[2*hw-1:hw]};
		else if (odd_pos)
			fe_in = {data_reg[hw-1:0], data_reg[2*hw-1:hw]};
		else
			fe_in = fl_inv_out; // Final FL^-1 layer
	end

	misty1_fo u_fo (
		.fo_in(fe_in[2*hw-1:hw]),
		.ko(rk.ko),
		.ki(rk.ki),
		.state(state),
		.sched_to_fi(rk.sched_to_fi),
		.fo_out(fo_out),
		.fi_to_sched(rk.fi_to_sched)
	);

	assign fe_out = {fe_in[2*hw-1:hw], fe_in[hw-1:0] ^ fo_out};
	assign fe_sel = last_pos ? fe_in : fe_out; // FO skipped on output cycle
	assign data_next = is_enc ? {fe_sel[hw-1:0], fe_sel[2*hw-1:hw]} : fe_sel;

	assign data_out = (last_pos && (state == misty1_pkg::st_encrypt ||
		state == misty1_pkg::st_decrypt)) ? data_next : '0;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			data_reg <= '0;
		end else begin
			case (state)
			misty1_pkg::st_idle: begin
				if (!key_rdy && data_rdy)
					data_reg <= is_enc ? data_in[2*hw-1:0] : {data_in[hw-1:0], data_in[2*hw-1:hw]};
			end
			misty1_pkg::st_encrypt, misty1_pkg::st_decrypt: data_reg <= data_next;
			default: ;
			endcase
		end
	end

endmodule

/* src/misty1_top.sv */
// MISTY1 cipher core
module misty1_top (
	input logic clk,
	input logic nreset,
	input logic key_rdy,
	input logic data_rdy,
	input logic enc_dec,
	input logic [misty1_pkg::key_w-1:0] data_in,
	output logic [misty1_pkg::block_w-1:0] data_out,
	output logic data_valid,
	output logic key_valid,
	output logic busy
);

	misty1_pkg::state_t state;
	misty1_pkg::round_t round;

	round_key_if rk ();

	misty1_control u_control (
		.clk(clk),
		.nreset(nreset),
		.key_rdy(key_rdy),
		.data_rdy(data_rdy),
		.enc_dec(enc_dec),
		.state(state),
		.round(round),
		.busy(busy),
		.key_valid(key_valid),
		.data_valid(data_valid)
	);

	misty1_key_sched u_key_sched (
		.clk(clk),
		.nreset(nreset),
		.key_rdy(key_rdy),
		.data_in(data_in),
		.enc_dec(enc_dec),
		.state(state),
		.round(round),
		.rk(rk.key_side)
	);

	misty1_datapath u_datapath (
		.clk(clk),
		.nreset(nreset),
		.data_rdy(data_rdy),
		.key_rdy(key_rdy),
		.enc_dec(enc_dec),
		.data_in(data_in),
		.state(state),
		.round(round),
		.data_out(data_out),
		.rk(rk.data_side)
	);

endmodule

/* testbench/tb_misty1.sv */
// MISTY1 core testbench
module tb_misty1;

	localparam int clk_half = 2;
	localparam int block_latency = 8; // Edges from load edge to data_valid
	localparam int sched_cycles = 8;

	logic clk;
	logic nreset;
	logic key_rdy;
	logic data_rdy;
	logic enc_dec;
	logic [127:0] data_in;
	logic [63:0] data_out;
	logic data_valid;
	logic key_valid;
	logic busy;

	logic [127:0] stim_mem [0:5];
	logic [31:0] rng_state;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;

	misty1_top uut (
		.clk(clk),
		.nreset(nreset),
		.key_rdy(key_rdy),
		.data_rdy(data_rdy),
		.enc_dec(enc_dec),
		.data_in(data_in),
		.data_out(data_out),
		.data_valid(data_valid),
		.key_valid(key_valid),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("error at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic load_key(input logic [127:0] key);
		int low_cycles;
		@(posedge clk);
		key_rdy <= 1'b1;
		data_in <= key;
		@(posedge clk); // Load edge
		key_rdy <= 1'b0;
		low_cycles = 0;
		@(negedge clk);
		while (!key_valid) begin
			low_cycles++;
			check("busy during key schedule", 64'(busy), 64'd1);
			@(negedge clk);
		end
		check("key schedule length", 64'(low_cycles), 64'(sched_cycles));
		check("busy after key schedule", 64'(busy), 64'd0);
	endtask

	// One block, optionally with stray requests while busy
	task automatic run_block(input logic dir, input logic [63:0] blk, input bit disturb,
			output logic [63:0] result);
		int edges;
		@(posedge clk);
		enc_dec <= dir;
		data_in <= {64'h0, blk};
		data_rdy <= 1'b1;
		@(posedge clk); // Load edge
		data_rdy <= 1'b0;
		edges = 0;
		@(negedge clk);
		while (!data_valid) begin
			@(posedge clk);
			edges++;
			// Lone data_rdy first, then lone key_rdy
			if (disturb && edges == 3) begin
				data_rdy <= 1'b1;
				data_in <= ~data_in;
			end else if (disturb && edges == 4) begin
				data_rdy <= 1'b0;
				key_rdy <= 1'b1;
			end else if (disturb && edges == 5) begin
				key_rdy <= 1'b0;
			end
			@(negedge clk);
		end
		result = data_out;
		check("data_valid latency", 64'(edges), 64'(block_latency));
		@(negedge clk);
		check("data_valid width", 64'(data_valid), 64'd0);
		check("busy after block", 64'(busy), 64'd0);
	endtask

	initial begin
		logic [63:0] result;
		logic [63:0] blk;
		logic [63:0] ct;
		int errors_before;
		int rt_count;
		nreset = 1'b0;
		key_rdy = 1'b0;
		data_rdy = 1'b0;
		enc_dec = 1'b0;
		data_in = '0;
		rng_state = 32'h7a75_4a45;
		$readmemh("testbench/misty1_stimulus.txt", stim_mem);
		rt_count = int'(stim_mem[5][31:0]);
		cycle_limit = (6 + 2 * rt_count) * 12 + 100; // Blocks and key load
		repeat (5) @(posedge clk);
		nreset <= 1'b1;

		errors_before = error_count;
		@(negedge clk);
		check("busy after reset", 64'(busy), 64'd0);
		check("key_valid after reset", 64'(key_valid), 64'd1);
		check("data_valid after reset", 64'(data_valid), 64'd0);
		check("data_out after reset", data_out, 64'h0);
		report_test("reset", errors_before);

		errors_before = error_count;
		load_key(stim_mem[0]);
		report_test("key load", errors_before);

		for (int i = 0; i < 2; i++) begin
			errors_before = error_count;
			run_block(1'b0, stim_mem[1 + 2 * i][63:0], 1'b0, result);
			check("ciphertext", result, stim_mem[2 + 2 * i][63:0]);
			report_test($sformatf("encrypt vector %0d", i), errors_before);
		end
		for (int i = 0; i < 2; i++) begin
			errors_before = error_count;
			run_block(1'b1, stim_mem[2 + 2 * i][63:0], 1'b0, result);
			check("plaintext", result, stim_mem[1 + 2 * i][63:0]);
			report_test($sformatf("decrypt vector %0d", i), errors_before);
		end

		errors_before = error_count;
		run_block(1'b0, stim_mem[1][63:0], 1'b1, result);
		check("ciphertext with requests while busy", result, stim_mem[2][63:0]);
		report_test("requests while busy", errors_before);

		for (int n = 0; n < rt_count; n++) begin
			errors_before = error_count;
			rng_state = lcg_next(rng_state);
			blk[63:32] = rng_state;
			rng_state = lcg_next(rng_state);
			blk[31:0] = rng_state;
			run_block(1'b0, blk, 1'b0, ct);
			run_block(1'b1, ct, 1'b0, result);
			check("round trip", result, blk);
			report_test($sformatf("round trip %0d", n), errors_before);
		end

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* misty1_top.f */
src/misty1_pkg.sv
src/round_key_if.sv
src/misty1_fi.sv
src/misty1_fo.sv
src/misty1_control.sv
src/misty1_key_sched.sv
src/misty1_datapath.sv
src/misty1_top.sv
testbench/tb_misty1.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MISTY1 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f misty1_top.f --top-module tb_misty1 -o tb_misty1
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_misty1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

/* testbench/misty1_stimulus.txt */
// Word 0 is the key, words 1 to 4 are plaintext/ciphertext pairs,
// word 5 is the number of random round trips
00112233445566778899aabbccddeeff
0123456789abcdef
8b1da5f56ab3d07c
fedcba9876543210
04b68240b13be95d
00000010
